// ==== common/tcp_tx_cfg.svh ====
`ifndef TCP_TX_CFG_SVH
`define TCP_TX_CFG_SVH

// payload buffer, 1 KiB by default
`define TCP_RAM_AW 10

// options area is 40 bytes at most
`define TCP_MAX_OPT_WORDS 10

// header length limits in bytes
`define TCP_MIN_HDR_LEN 20
`define TCP_MAX_HDR_LEN 60

`endif

// ==== common/tcp_tx_pkg.sv ====
`include "tcp_tx_cfg.svh"

package tcp_tx_pkg;

    // option kind bytes as they appear on the wire
    typedef enum logic [7:0] {
        TCP_OPT_END       = 8'd0,
        TCP_OPT_NOP       = 8'd1,
        TCP_OPT_MSS       = 8'd2,
        TCP_OPT_WIN       = 8'd3,
        TCP_OPT_SACK_PERM = 8'd4,
        TCP_OPT_SACK      = 8'd5,
        TCP_OPT_TS        = 8'd8
    } tcp_opt_kind_e;

    typedef struct packed {
        logic [31:0] left;  // first seq of the block
        logic [31:0] right; // seq following the block
    } tcp_sack_blk_t;

    typedef struct packed {
        logic                  mss_pres;
        logic [15:0]           mss;
        logic                  win_pres;
        logic [7:0]            win_shift;
        logic                  sack_perm;   // flag is its own presence bit
        logic [2:0]            sack_blocks; // 0 means no sack option
        tcp_sack_blk_t [0:3]   sack;
        logic                  ts_pres;
        logic [31:0]           ts_val;
        logic [31:0]           ts_ecr;
    } tcp_opts_t;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [31:0] seq;
        logic [31:0] ack;
        logic [8:0]  flags; // ns .. fin
        logic [15:0] win;
        logic [15:0] urg;
    } tcp_hdr_t;

    // everything the host hands over for one segment
    typedef struct packed {
        tcp_hdr_t    hdr;
        tcp_opts_t   opts;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] pay_len;
        logic [15:0] pay_chsum; // ones-complement sum of payload, not inverted
    } tcp_seg_t;

    typedef struct packed {
        logic [0:`TCP_MAX_OPT_WORDS-1][31:0] words; // word 0 goes out first
        logic [3:0]                          cnt;
    } tcp_opt_words_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sof;
        logic       eof;
    } tcp_strm_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BUILD,
        ST_CALC,
        ST_HDR,
        ST_PAY
    } tcp_tx_state_e;

endpackage

// ==== tcp_tx/tcp_opt_builder.sv ====
`include "tcp_tx_cfg.svh"

module tcp_opt_builder (
    input  logic                       clk,
    input  logic                       fsm_rst,
    input  logic                       build,
    input  tcp_tx_pkg::tcp_opts_t      opts_in,
    output tcp_tx_pkg::tcp_opt_words_t opts,
    output logic                       opt_done
);

    logic [0:14][31:0] proto; // every possible option word, in wire order
    logic [0:14]       pres;
    logic [0:14]       pres_in;
    logic [7:0]        sack_len;
    logic              scan;
    logic [3:0]        slot;

    assign sack_len = {2'b00, opts_in.sack_blocks, 3'b000} + 8'd2; // 8n+2

    // presence per slot, sack blocks gated by count
    assign pres_in = {
        opts_in.mss_pres,
        opts_in.win_pres,
        opts_in.sack_perm,
        opts_in.sack_blocks != 3'd0,
        {2{opts_in.sack_blocks > 3'd0}},
        {2{opts_in.sack_blocks > 3'd1}},
        {2{opts_in.sack_blocks > 3'd2}},
        {2{opts_in.sack_blocks > 3'd3}},
        {3{opts_in.ts_pres}}
    };

    always_ff @(posedge clk) begin
        if (fsm_rst) begin
            scan     <= 1'b0;
            slot     <= 4'd0;
            opt_done <= 1'b0;
            opts.cnt <= 4'd0;
        end else begin
            opt_done <= 1'b0; // single-cycle pulse
            if (build) begin
                proto <= {
                    {tcp_tx_pkg::TCP_OPT_MSS, 8'd4, opts_in.mss},
                    {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_WIN, 8'd3, opts_in.win_shift},
                    {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_NOP,
                     tcp_tx_pkg::TCP_OPT_SACK_PERM, 8'd2},
                    {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_NOP,
                     tcp_tx_pkg::TCP_OPT_SACK, sack_len},
                    opts_in.sack,
                    {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_NOP,
                     tcp_tx_pkg::TCP_OPT_TS, 8'd10},
                    opts_in.ts_val,
                    opts_in.ts_ecr
                };
                pres       <= pres_in;
                opts.words <= '0;
                opts.cnt   <= 4'd0;
                slot       <= 4'd0;
                scan       <= (pres_in != '0);
                opt_done   <= (pres_in == '0); // nothing to scan, done right away
            end else if (scan) begin
                proto <= {proto[1:14], 32'h0}; // next slot to the head
                pres  <= {pres[1:14], 1'b0};
                slot  <= slot + 4'd1;
                // append if present and still room, later words fall off
                if (pres[0] && opts.cnt < 4'(`TCP_MAX_OPT_WORDS)) begin
                    opts.words[opts.cnt] <= proto[0];
                    opts.cnt             <= opts.cnt + 4'd1;
                end
                if (slot == 4'd14) begin
                    scan     <= 1'b0;
                    opt_done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== tcp_tx/tcp_chsum_calc.sv ====
`include "tcp_tx_cfg.svh"

module tcp_chsum_calc (
    input  logic                       clk,
    input  logic                       fsm_rst,
    input  logic                       calc_start,
    input  tcp_tx_pkg::tcp_seg_t       seg,
    input  tcp_tx_pkg::tcp_opt_words_t opts,
    input  logic [5:0]                 hdr_len,
    output logic [15:0]                chsum,
    output logic                       chsum_done
);

    logic [15:0]                     tcp_len;
    logic [95:0]                     p_img; // 12-byte pseudo header
    logic [`TCP_MAX_HDR_LEN*8-1:0]   h_img; // header with zero chsum field
    logic [79:0]                     pimg;
    logic [`TCP_MAX_HDR_LEN*8-1:0]   himg;
    logic [31:0]                     pacc, hacc;
    logic [5:0]                      cnt;
    logic                            run, fold;
    logic [31:0]                     sum;
    logic [16:0]                     f1;
    logic [15:0]                     f2;

    assign tcp_len = {10'd0, hdr_len} + seg.pay_len;
    assign p_img   = {seg.src_ip, seg.dst_ip, 8'h00, 8'd6, tcp_len};
    assign h_img   = {seg.hdr.src_port, seg.hdr.dst_port, seg.hdr.seq, seg.hdr.ack,
                      hdr_len[5:2], 3'b000, seg.hdr.flags, seg.hdr.win,
                      16'h0000, seg.hdr.urg, opts.words};

    // final sum and two carry folds
    assign sum = pacc + hacc + {16'd0, seg.pay_chsum};
    assign f1  = {1'b0, sum[31:16]} + {1'b0, sum[15:0]};
    assign f2  = f1[15:0] + {15'd0, f1[16]};

    always_ff @(posedge clk) begin
        if (fsm_rst) begin
            run        <= 1'b0;
            fold       <= 1'b0;
            cnt        <= 6'd0;
            chsum_done <= 1'b0;
        end else begin
            chsum_done <= 1'b0;
            if (calc_start) begin
                run <= 1'b1;
                cnt <= 6'd1; // first pseudo word taken at load
            end else if (run) begin
                cnt <= cnt + 6'd1;
                // 6 pseudo words then hdr_len/2 header words
                if (cnt == 6'd5 + {1'b0, hdr_len[5:1]}) begin
                    run  <= 1'b0;
                    fold <= 1'b1;
                end
            end else if (fold) begin
                fold       <= 1'b0;
                chsum_done <= 1'b1;
            end
        end
    end

    // pseudo and header images shift out 16 bits per cycle
    always_ff @(posedge clk) begin
        if (calc_start) begin
            pimg <= p_img[79:0];
            pacc <= {16'd0, p_img[95:80]};
            himg <= h_img;
            hacc <= 32'd0;
        end else if (run) begin
            if (cnt < 6'd6) begin
                pacc <= pacc + {16'd0, pimg[79:64]};
                pimg <= {pimg[63:0], 16'h0};
            end else begin
                hacc <= hacc + {16'd0, himg[`TCP_MAX_HDR_LEN*8-1 -: 16]};
                himg <= {himg[`TCP_MAX_HDR_LEN*8-17:0], 16'h0};
            end
        end
        if (fold) chsum <= ~f2;
    end

endmodule

// ==== tcp_tx/tcp_seg_tx.sv ====
`include "tcp_tx_cfg.svh"

module tcp_seg_tx (
    input  logic                       clk,
    input  logic                       fsm_rst,
    input  logic                       seg_v,
    input  tcp_tx_pkg::tcp_seg_t       seg,
    output logic                       build,
    input  logic                       opt_done,
    input  tcp_tx_pkg::tcp_opt_words_t opts,
    output logic                       calc_start,
    output tcp_tx_pkg::tcp_seg_t       seg_q,
    output logic [5:0]                 hdr_len,
    input  logic                       chsum_done,
    input  logic [15:0]                chsum,
    output logic [`TCP_RAM_AW-1:0]     rd_addr,
    input  logic [7:0]                 rd_data,
    output tcp_tx_pkg::tcp_strm_t      stream,
    output logic                       busy
);

    tcp_tx_pkg::tcp_tx_state_e          state;
    logic [0:`TCP_MAX_HDR_LEN-1][7:0]   sr;      // wire-order header bytes
    logic [16:0]                        bcnt;    // index of byte on the stream
    logic [16:0]                        tot_len; // header plus payload
    logic                               v_q, sof_q, eof_q;
    logic                               last_hdr;

    assign busy       = (state != tcp_tx_pkg::ST_IDLE);
    assign build      = seg_v && (state == tcp_tx_pkg::ST_IDLE);
    assign calc_start = opt_done && (state == tcp_tx_pkg::ST_BUILD);
    assign hdr_len    = 6'(`TCP_MIN_HDR_LEN) + {opts.cnt, 2'b00};
    assign last_hdr   = (state == tcp_tx_pkg::ST_HDR) &&
                        (bcnt == {11'd0, hdr_len} - 17'd1);

    always_ff @(posedge clk) begin
        if (fsm_rst) begin
            state <= tcp_tx_pkg::ST_IDLE;
            v_q   <= 1'b0;
            sof_q <= 1'b0;
            eof_q <= 1'b0;
            bcnt  <= 17'd0;
        end else begin
            sof_q <= 1'b0;
            case (state)
                tcp_tx_pkg::ST_IDLE:  if (seg_v) state <= tcp_tx_pkg::ST_BUILD;
                tcp_tx_pkg::ST_BUILD: if (opt_done) state <= tcp_tx_pkg::ST_CALC;
                tcp_tx_pkg::ST_CALC: begin
                    if (chsum_done) begin // first byte next cycle
                        state <= tcp_tx_pkg::ST_HDR;
                        v_q   <= 1'b1;
                        sof_q <= 1'b1;
                        bcnt  <= 17'd0;
                    end
                end
                tcp_tx_pkg::ST_HDR, tcp_tx_pkg::ST_PAY: begin
                    bcnt  <= bcnt + 17'd1;
                    eof_q <= (bcnt == tot_len - 17'd2); // next byte is the last
                    if (eof_q) begin
                        state <= tcp_tx_pkg::ST_IDLE;
                        v_q   <= 1'b0;
                        eof_q <= 1'b0;
                    end else if (last_hdr) begin
                        state <= tcp_tx_pkg::ST_PAY; // zero payload ends via eof above
                    end
                end
                default: state <= tcp_tx_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (build) begin
            seg_q   <= seg;
            rd_addr <= seg.hdr.seq[`TCP_RAM_AW-1:0]; // payload starts at seq low bits
        end else if (last_hdr || state == tcp_tx_pkg::ST_PAY) begin
            rd_addr <= rd_addr + 1'b1; // one ahead of the data, wraps
        end
        if (state == tcp_tx_pkg::ST_CALC && chsum_done) begin
            sr <= {seg_q.hdr.src_port, seg_q.hdr.dst_port, seg_q.hdr.seq, seg_q.hdr.ack,
                   4'd5 + opts.cnt, 3'b000, seg_q.hdr.flags, seg_q.hdr.win,
                   chsum, seg_q.hdr.urg, opts.words};
            tot_len <= {11'd0, hdr_len} + {1'b0, seg_q.pay_len};
        end else if (state == tcp_tx_pkg::ST_HDR) begin
            sr <= {sr[1:`TCP_MAX_HDR_LEN-1], 8'h00}; // one byte per cycle
        end
    end

    // data muxed between header shifter and ram
    always_comb begin
        stream.data  = (state == tcp_tx_pkg::ST_PAY) ? rd_data : sr[0];
        stream.valid = v_q;
        stream.sof   = sof_q;
        stream.eof   = eof_q;
    end

endmodule

// ==== rtl/payload_ram.sv ====
module payload_ram #(
    parameter int DEPTH_AW = 10
) (
    input  logic                clk,
    input  logic                we,
    input  logic [DEPTH_AW-1:0] waddr,
    input  logic [7:0]          wdata,
    input  logic [DEPTH_AW-1:0] raddr,
    output logic [7:0]          rdata
);

    logic [7:0] mem [0:(1 << DEPTH_AW)-1]; // byte per entry

    // host side write
    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    // data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== rtl/tcp_tx_top.sv ====
`include "tcp_tx_cfg.svh"

module tcp_tx_top (
    input  logic                   clk,
    input  logic                   fsm_rst,
    input  logic                   seg_v,
    input  tcp_tx_pkg::tcp_seg_t   seg,
    input  logic                   pay_we,
    input  logic [`TCP_RAM_AW-1:0] pay_waddr,
    input  logic [7:0]             pay_wdata,
    output tcp_tx_pkg::tcp_strm_t  stream,
    output logic                   busy
);

    logic                       build, opt_done;
    logic                       calc_start, chsum_done;
    tcp_tx_pkg::tcp_opt_words_t opts;
    tcp_tx_pkg::tcp_seg_t       seg_q;
    logic [5:0]                 hdr_len;
    logic [15:0]                chsum;
    logic [`TCP_RAM_AW-1:0]     rd_addr;
    logic [7:0]                 rd_data;

    // build fires in the seg_v cycle, so options come straight from the input
    tcp_opt_builder u_opt (
        .clk(clk), .fsm_rst(fsm_rst), .build(build), .opts_in(seg.opts),
        .opts(opts), .opt_done(opt_done)
    );

    tcp_chsum_calc u_chsum (
        .clk(clk), .fsm_rst(fsm_rst), .calc_start(calc_start), .seg(seg_q),
        .opts(opts), .hdr_len(hdr_len), .chsum(chsum), .chsum_done(chsum_done)
    );

    tcp_seg_tx u_seg (
        .clk(clk), .fsm_rst(fsm_rst), .seg_v(seg_v), .seg(seg), .build(build),
        .opt_done(opt_done), .opts(opts), .calc_start(calc_start), .seg_q(seg_q),
        .hdr_len(hdr_len), .chsum_done(chsum_done), .chsum(chsum),
        .rd_addr(rd_addr), .rd_data(rd_data), .stream(stream), .busy(busy)
    );

    payload_ram #(.DEPTH_AW(`TCP_RAM_AW)) u_ram (
        .clk(clk), .we(pay_we), .waddr(pay_waddr), .wdata(pay_wdata),
        .raddr(rd_addr), .rdata(rd_data)
    );

endmodule

// ==== bench/tcp_tx_properties.sv ====
module tcp_tx_properties (
    input logic                  clk,
    input logic                  fsm_rst,
    input logic                  seg_v,
    input logic                  busy,
    input tcp_tx_pkg::tcp_strm_t stream
);

    // sof and eof only mark bytes that are on the stream
    a_sof_valid: assert property (@(posedge clk) disable iff (fsm_rst)
        stream.sof |-> stream.valid)
        else $error("sof seen without valid");

    a_eof_valid: assert property (@(posedge clk) disable iff (fsm_rst)
        stream.eof |-> stream.valid)
        else $error("eof seen without valid");

    // no gap inside a segment
    a_valid_cont: assert property (@(posedge clk) disable iff (fsm_rst)
        (stream.valid && !stream.eof) |=> stream.valid)
        else $error("valid dropped between sof and eof");

    a_valid_start: assert property (@(posedge clk) disable iff (fsm_rst)
        $rose(stream.valid) |-> stream.sof) // a segment opens with sof
        else $error("valid rose without sof");

    // host may only start a segment while idle
    a_seg_v_idle: assert property (@(posedge clk) disable iff (fsm_rst)
        seg_v |-> !busy)
        else $error("seg_v pulsed while busy");

endmodule

bind tcp_tx_top tcp_tx_properties u_props (
    .clk(clk), .fsm_rst(fsm_rst), .seg_v(seg_v), .busy(busy), .stream(stream)
);

// ==== bench/tcp_tx_tb.sv ====
`include "tcp_tx_cfg.svh"

module tcp_tx_tb;

    localparam int DRIVE_DLY = 10; // input skew after the rising edge

    logic                   clk;
    logic                   fsm_rst;
    logic                   seg_v;
    tcp_tx_pkg::tcp_seg_t   seg;
    logic                   pay_we;
    logic [`TCP_RAM_AW-1:0] pay_waddr;
    logic [7:0]             pay_wdata;
    tcp_tx_pkg::tcp_strm_t  stream;
    logic                   busy;

    logic [7:0] pay_buf [0:(1 << `TCP_RAM_AW)-1]; // payload indexed by offset from seq
    logic [7:0] exp_bytes [$];                      // expected bytes of every segment
    int         exp_lens [$];
    int         seg_sent, seg_done;
    int         cycles;
    int         cycle_limit = 40;                   // reset plus margin to start with
    logic       capturing, after_eof;
    int         got_cnt, cur_len;

    tcp_tx_top i_dut (
        .clk(clk), .fsm_rst(fsm_rst), .seg_v(seg_v), .seg(seg), .pay_we(pay_we),
        .pay_waddr(pay_waddr), .pay_wdata(pay_wdata), .stream(stream), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // 16-bit add with end-around carry
    function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + {15'd0, s[16]};
    endfunction

    // big-endian byte pairs with a zero-padded odd tail
    function automatic logic [15:0] pay_sum(input int len);
        logic [15:0] sum;
        logic [7:0]  lo;
        sum = 16'h0000;
        for (int i = 0; i < len; i += 2) begin
            lo  = (i + 1 < len) ? pay_buf[i + 1] : 8'h00;
            sum = ones_add(sum, {pay_buf[i], lo});
        end
        return sum;
    endfunction

    // appends the expected wire bytes of one segment to exp_bytes
    function automatic int tcp_expect(input tcp_tx_pkg::tcp_seg_t s);
        logic [31:0]  ow [$];
        logic [159:0] fh;
        logic [15:0]  sum;
        logic [15:0]  tlen;
        int           hl;
        int           nsack;
        nsack = int'(s.opts.sack_blocks);
        if (s.opts.mss_pres) ow.push_back({8'd2, 8'd4, s.opts.mss});
        if (s.opts.win_pres) ow.push_back({8'd1, 8'd3, 8'd3, s.opts.win_shift});
        if (s.opts.sack_perm) ow.push_back({8'd1, 8'd1, 8'd4, 8'd2});
        if (nsack > 0) begin
            ow.push_back({8'd1, 8'd1, 8'd5, 8'(8 * nsack + 2)});
            for (int k = 0; k < nsack; k++) begin
                ow.push_back(s.opts.sack[k].left);
                ow.push_back(s.opts.sack[k].right);
            end
        end
        if (s.opts.ts_pres) begin
            ow.push_back({8'd1, 8'd1, 8'd8, 8'd10});
            ow.push_back(s.opts.ts_val);
            ow.push_back(s.opts.ts_ecr);
        end
        while (ow.size() > `TCP_MAX_OPT_WORDS) ow.pop_back(); // words past the cap dropped
        hl   = `TCP_MIN_HDR_LEN + 4 * ow.size();
        tlen = 16'(hl + int'(s.pay_len));
        fh   = {s.hdr.src_port, s.hdr.dst_port, s.hdr.seq, s.hdr.ack,
                4'(5 + ow.size()), 3'b000, s.hdr.flags, s.hdr.win, 16'h0000, s.hdr.urg};
        // pseudo header first
        sum = ones_add(16'h0000, s.src_ip[31:16]);
        sum = ones_add(sum, s.src_ip[15:0]);
        sum = ones_add(sum, s.dst_ip[31:16]);
        sum = ones_add(sum, s.dst_ip[15:0]);
        sum = ones_add(sum, 16'h0006);
        sum = ones_add(sum, tlen);
        for (int i = 0; i < 10; i++) sum = ones_add(sum, fh[159 - 16 * i -: 16]);
        foreach (ow[i]) begin
            sum = ones_add(sum, ow[i][31:16]);
            sum = ones_add(sum, ow[i][15:0]);
        end
        sum       = ones_add(sum, pay_sum(int'(s.pay_len)));
        fh[31:16] = ~sum; // checksum field sits after the window
        for (int i = 0; i < 20; i++) exp_bytes.push_back(fh[159 - 8 * i -: 8]);
        foreach (ow[i]) begin
            for (int b = 0; b < 4; b++) exp_bytes.push_back(ow[i][31 - 8 * b -: 8]);
        end
        for (int i = 0; i < int'(s.pay_len); i++) exp_bytes.push_back(pay_buf[i]);
        return hl + int'(s.pay_len);
    endfunction

    task automatic check_byte(input tcp_tx_pkg::tcp_strm_t got, input logic [7:0] exp,
                              input int idx);
        if (got.data !== exp)
            fail_run($sformatf("Mismatch stream.data byte %0d: got 0x%02h expected 0x%02h",
                               idx, got.data, exp));
    endtask

    task automatic check_strm_len(input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("Mismatch stream length: got 0x%0h expected 0x%0h", got, exp));
    endtask

    task automatic verify_busy(input logic got, input logic exp, input string where);
        if (got !== exp)
            fail_run($sformatf("Mismatch busy (%s): got 0x%0h expected 0x%0h", where, got, exp));
    endtask

    // random header with options only when asked for
    function automatic tcp_tx_pkg::tcp_seg_t rand_seg(input int pay_max, input bit with_opts);
        tcp_tx_pkg::tcp_seg_t s;
        s              = '0;
        s.hdr.src_port = 16'($urandom);
        s.hdr.dst_port = 16'($urandom);
        s.hdr.seq      = $urandom;
        s.hdr.ack      = $urandom;
        s.hdr.flags    = 9'($urandom);
        s.hdr.win      = 16'($urandom);
        s.hdr.urg      = 16'($urandom);
        s.src_ip       = $urandom;
        s.dst_ip       = $urandom;
        s.opts.mss       = 16'($urandom);
        s.opts.win_shift = 8'($urandom);
        s.opts.ts_val    = $urandom;
        s.opts.ts_ecr    = $urandom;
        for (int k = 0; k < 4; k++) begin
            s.opts.sack[k].left  = $urandom;
            s.opts.sack[k].right = $urandom;
        end
        if (with_opts) begin
            s.opts.mss_pres    = 1'($urandom);
            s.opts.win_pres    = 1'($urandom);
            s.opts.sack_perm   = 1'($urandom);
            s.opts.sack_blocks = 3'($urandom_range(0, 4));
            s.opts.ts_pres     = 1'($urandom);
        end
        s.pay_len = 16'($urandom_range(0, pay_max));
        return s;
    endfunction

    // ram written from the seq low bits upward with wraparound
    task automatic load_payload(input logic [31:0] seq, input int len);
        logic [31:0] a;
        for (int i = 0; i < len; i++) begin
            pay_buf[i] = 8'($urandom);
            a          = seq + 32'(i);
            next_cycle();
            pay_we     = 1'b1;
            pay_waddr  = a[`TCP_RAM_AW-1:0];
            pay_wdata  = pay_buf[i];
        end
        next_cycle();
        pay_we = 1'b0;
    endtask

    task automatic send_seg(input tcp_tx_pkg::tcp_seg_t s);
        cycle_limit += 200 + 2 * int'(s.pay_len); // writes plus stream
        load_payload(s.hdr.seq, int'(s.pay_len));
        s.pay_chsum = pay_sum(int'(s.pay_len));
        exp_lens.push_back(tcp_expect(s));
        next_cycle();
        seg   = s;
        seg_v = 1'b1;
        next_cycle();
        seg_v = 1'b0;
        verify_busy(busy, 1'b1, "cycle after seg_v");
        do begin
            next_cycle();
        end while (busy); // next segment only once idle
        seg_sent++;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit)
            fail_run($sformatf("Timeout: stream not finished after %0d cycles", cycle_limit));
    end

    // stream capture and compare at mid-cycle
    always @(negedge clk) begin
        if (fsm_rst) begin
            capturing = 1'b0;
            after_eof = 1'b0;
        end else begin
            if (after_eof) begin
                verify_busy(busy, 1'b0, "cycle after eof");
                after_eof = 1'b0;
            end
            if (stream.valid) begin
                verify_busy(busy, 1'b1, "during stream");
                if (stream.sof) begin
                    if (capturing) fail_run("sof arrived inside an open segment");
                    if (exp_lens.size() == 0) fail_run("segment appeared with none expected");
                    capturing = 1'b1;
                    got_cnt   = 0;
                    cur_len   = exp_lens.pop_front();
                end else if (!capturing) begin
                    fail_run("valid byte seen outside a segment");
                end
                got_cnt++;
                if (got_cnt > cur_len) check_strm_len(got_cnt, cur_len); // runs past the end
                check_byte(stream, exp_bytes.pop_front(), got_cnt - 1);
                if (stream.eof) begin
                    check_strm_len(got_cnt, cur_len);
                    capturing = 1'b0;
                    after_eof = 1'b1;
                    seg_done++;
                end
            end else if (capturing) begin
                fail_run("valid dropped before eof");
            end
        end
    end

    initial begin
        tcp_tx_pkg::tcp_seg_t s;
        void'($urandom(76501));
        fsm_rst   = 1'b1;
        seg_v     = 1'b0;
        seg       = '0;
        pay_we    = 1'b0;
        pay_waddr = '0;
        pay_wdata = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DLY fsm_rst = 1'b0;

        s = rand_seg(0, 1'b0); // bare 20-byte header
        send_seg(s);

        // each option alone
        s = rand_seg(0, 1'b0);
        s.opts.mss_pres = 1'b1;
        send_seg(s);
        s = rand_seg(0, 1'b0);
        s.opts.win_pres = 1'b1;
        send_seg(s);
        s = rand_seg(0, 1'b0);
        s.opts.sack_perm = 1'b1;
        send_seg(s);
        s = rand_seg(0, 1'b0);
        s.opts.ts_pres = 1'b1;
        send_seg(s);

        // sack plus timestamp up to and past the ten-word cap
        for (int k = 1; k <= 4; k++) begin
            s = rand_seg(16, 1'b0);
            s.opts.sack_blocks = 3'(k);
            s.opts.ts_pres     = 1'b1;
            send_seg(s);
        end
        s = rand_seg(16, 1'b0);
        s.opts.mss_pres    = 1'b1;
        s.opts.win_pres    = 1'b1;
        s.opts.sack_perm   = 1'b1;
        s.opts.sack_blocks = 3'd4;
        s.opts.ts_pres     = 1'b1; // 15 words offered
        send_seg(s);

        // payload from the top of the ram wrapping to address 0
        s = rand_seg(0, 1'b1);
        s.hdr.seq[`TCP_RAM_AW-1:0] = {`TCP_RAM_AW{1'b1}};
        s.pay_len = 16'd64;
        send_seg(s);
        s = rand_seg(0, 1'b0);
        s.pay_len = 16'd33; // odd tail byte
        send_seg(s);

        repeat (50) begin
            s = rand_seg(300, 1'b1);
            send_seg(s);
        end

        next_cycle();
        if (seg_done == seg_sent && exp_bytes.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            fail_run($sformatf("only %0d of %0d segments came out complete",
                               seg_done, seg_sent));
        end
    end

endmodule

// ==== flist.f ====
+incdir+common
common/tcp_tx_pkg.sv
tcp_tx/tcp_opt_builder.sv
tcp_tx/tcp_chsum_calc.sv
tcp_tx/tcp_seg_tx.sv
rtl/payload_ram.sv
rtl/tcp_tx_top.sv
bench/tcp_tx_properties.sv
bench/tcp_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tcp_tx_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) common/tcp_tx_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulation is the result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
